/* src/agu_pkg.sv */
// agu package with widths, size codes and the structs shared by the address stage
package agu_pkg;

  localparam int VADDR_W     = 44;
  localparam int PADDR_W     = 44;
  localparam int PAGE_BITS   = 13;
  localparam int LINE_BITS   = 7;
  localparam int VPN_W       = VADDR_W - PAGE_BITS;
  localparam int PPN_W       = PADDR_W - PAGE_BITS;
  localparam int LINE_IDX_W  = PAGE_BITS - LINE_BITS;
  localparam int BANK_COUNT  = 32;
  localparam int TLB_ENTRIES = 16;
  localparam int TLB_IDX_W   = 4;
  localparam int TLB_TAG_W   = VPN_W - TLB_IDX_W;

  // size codes
  localparam logic [4:0] SZ_B8   = 5'd16;
  localparam logic [4:0] SZ_B16  = 5'd17;
  localparam logic [4:0] SZ_B32  = 5'd18;
  localparam logic [4:0] SZ_B64  = 5'd19;
  localparam logic [4:0] SZ_LDBL = 5'd3;
  localparam logic [4:0] SZ_FILL = 5'd15;

  // attribute bits
  localparam int ATTR_KM = 0;

  // tags carried through untouched
  typedef struct packed {
    logic [8:0] reg_no;
    logic [8:0] lsq;
    logic [9:0] ii;
    logic [5:0] wq;
  } op_tag_t;

  typedef struct packed {
    logic               valid;
    logic [VADDR_W-1:0] addr;
    logic [4:0]         sz;
    logic               st;
    logic               split;
    logic [3:0]         attr;
    op_tag_t            tag;
  } mem_op_in_t;

  // even and odd line addresses keep physical bits 43 down to 8
  typedef struct packed {
    logic                         en;
    logic [PADDR_W-1:LINE_BITS+1] addr_even;
    logic [PADDR_W-1:LINE_BITS+1] addr_odd;
    logic                         odd;
    logic [1:0]                   addr_low;
    logic [4:0]                   sz;
    logic                         st;
    logic                         split;
    logic [BANK_COUNT-1:0]        banks;
    op_tag_t                      tag;
  } mem_op_out_t;

  typedef struct packed {
    logic                 valid;
    logic [TLB_TAG_W-1:0] tag;
    logic [PPN_W-1:0]     ppn;
    logic                 sys;
    logic                 na;
  } tlb_entry_t;

  typedef struct packed {
    logic             en;
    logic [VPN_W-1:0] vpn;
    logic [PPN_W-1:0] ppn;
    logic             sys;
    logic             na;
  } tlb_fill_t;

  typedef struct packed {
    logic       page_fault;
    logic [7:0] code;
    logic [8:0] no;
  } fault_t;

endpackage

/* src/op_stage.sv */
// operation stage register, holds one memory op until it is translated and issued
module op_stage (
  input  logic                clk,
  input  logic                rst,
  input  agu_pkg::mem_op_in_t op_in,
  input  logic                hold,
  input  logic                except,
  input  logic                translated,
  output logic                stall,
  output agu_pkg::mem_op_in_t stage_op,
  output logic                issue
);
  import agu_pkg::*;

  logic       valid_q;
  mem_op_in_t op_q;

  // stuck on a miss or on bus hold
  assign stall = (valid_q & ~translated) | hold;
  assign issue = valid_q & translated & ~hold & ~except;

  always_comb begin
    stage_op       = op_q;
    stage_op.valid = valid_q;
  end

  // a free stage either was empty or issues this cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (except) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= op_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && op_in.valid) begin
      op_q <= op_in;
    end
  end

  a_no_issue_in_stall: assert property (
    @(posedge clk) disable iff (rst) issue |-> !stall
  ) else $error("op_stage issued while stalled");

endmodule

/* src/dtlb.sv */
// data TLB, direct mapped, looks up a page and the page after it, one fill port
module dtlb (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [agu_pkg::VPN_W-1:0] vpn_main,
  input  agu_pkg::tlb_fill_t        fill,
  output logic                      hit_main,
  output logic                      hit_next,
  output agu_pkg::tlb_entry_t       entry_main,
  output agu_pkg::tlb_entry_t       entry_next
);
  import agu_pkg::*;

  tlb_entry_t             mem [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [VPN_W-1:0]       vpn_next;
  logic [TLB_IDX_W-1:0]   idx_main;
  logic [TLB_IDX_W-1:0]   idx_next;
  logic [TLB_IDX_W-1:0]   idx_fill;

  assign vpn_next = vpn_main + VPN_W'(1);
  assign idx_main = vpn_main[TLB_IDX_W-1:0];
  assign idx_next = vpn_next[TLB_IDX_W-1:0];
  assign idx_fill = fill.vpn[TLB_IDX_W-1:0];

  // valid comes from the resettable bit vector
  always_comb begin
    entry_main       = mem[idx_main];
    entry_main.valid = valid_q[idx_main];
    entry_next       = mem[idx_next];
    entry_next.valid = valid_q[idx_next];
  end

  assign hit_main = entry_main.valid && (entry_main.tag == vpn_main[VPN_W-1:TLB_IDX_W]);
  assign hit_next = entry_next.valid && (entry_next.tag == vpn_next[VPN_W-1:TLB_IDX_W]);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill.en) begin
      valid_q[idx_fill] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill.en) begin
      mem[idx_fill] <= '{valid: 1'b1,
                         tag:   fill.vpn[VPN_W-1:TLB_IDX_W],
                         ppn:   fill.ppn,
                         sys:   fill.sys,
                         na:    fill.na};
    end
  end

endmodule

/* src/line_addr_split.sv */
// line address split, forms the even and odd physical line addresses of the access window
module line_addr_split (
  input  logic [agu_pkg::VADDR_W-1:0]                    addr,
  input  agu_pkg::tlb_entry_t                            entry_main,
  input  agu_pkg::tlb_entry_t                            entry_next,
  output logic                                           page_carry,
  output logic [agu_pkg::PADDR_W-1:agu_pkg::LINE_BITS+1] addr_even,
  output logic [agu_pkg::PADDR_W-1:agu_pkg::LINE_BITS+1] addr_odd
);
  import agu_pkg::*;

  logic [LINE_IDX_W-1:0] line_idx;
  logic [LINE_IDX_W-1:0] line_inc;
  logic                  odd_line;
  logic                  even_far;

  assign line_idx = addr[PAGE_BITS-1:LINE_BITS];
  assign {page_carry, line_inc} = {1'b0, line_idx} + (LINE_IDX_W + 1)'(1);

  assign odd_line = addr[LINE_BITS];

  // odd start puts the even line one step ahead
  assign addr_even[PAGE_BITS-1:LINE_BITS+1] =
    odd_line ? line_inc[LINE_IDX_W-1:1] : addr[PAGE_BITS-1:LINE_BITS+1];
  assign addr_odd[PAGE_BITS-1:LINE_BITS+1] =
    odd_line ? addr[PAGE_BITS-1:LINE_BITS+1] : line_inc[LINE_IDX_W-1:1];

  // line past the carry lives in the next page
  assign even_far = page_carry & odd_line;

  assign addr_even[PADDR_W-1:PAGE_BITS] = even_far ? entry_next.ppn : entry_main.ppn;
  assign addr_odd[PADDR_W-1:PAGE_BITS]  = entry_main.ppn;

endmodule

/* src/bank_mask_gen.sv */
// bank mask generator, turns size code and low address into the 4-byte banks touched
module bank_mask_gen (
  input  logic [agu_pkg::LINE_BITS-1:0]  addr_low,
  input  logic [4:0]                     sz,
  output logic [agu_pkg::BANK_COUNT-1:0] banks
);
  import agu_pkg::*;

  logic [4:0]              n_bytes;
  logic [4:0]              last_byte;
  logic [2:0]              n_raw;
  logic [2:0]              n_banks;
  logic [4:0]              first;
  logic [BANK_COUNT-1:0]   run;
  logic [2*BANK_COUNT-1:0] rot;

  always_comb begin
    case (sz)
      SZ_B8:   n_bytes = 5'd1;
      SZ_B16:  n_bytes = 5'd2;
      SZ_B32:  n_bytes = 5'd4;
      SZ_B64:  n_bytes = 5'd8;
      // long double
      SZ_LDBL: n_bytes = 5'd10;
      // 128-bit int and float forms
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: n_bytes = 5'd16;
      5'd4, 5'd5, 5'd6:  n_bytes = 5'd4;
      5'd8, 5'd9, 5'd10: n_bytes = 5'd8;
      // 160-bit fill and spill
      SZ_FILL: n_bytes = 5'd20;
      default: n_bytes = 5'd8;
    endcase
  end

  // offset of the last byte from the first bank start
  assign last_byte = n_bytes + {3'b000, addr_low[1:0]} - 5'd1;
  assign n_raw     = last_byte[4:2] + 3'd1;
  assign n_banks   = (n_raw > 3'd5) ? 3'd5 : n_raw;
  assign first     = addr_low[LINE_BITS-1:2];

  assign run = (BANK_COUNT'(1) << n_banks) - BANK_COUNT'(1);

  // rotate the run to the first bank, upper half wraps past bank 31
  assign rot   = {{BANK_COUNT{1'b0}}, run} << first;
  assign banks = rot[BANK_COUNT-1:0] | rot[2*BANK_COUNT-1:BANK_COUNT];

endmodule

/* src/tlb_miss_ctrl.sv */
// TLB miss control, raises one miss request per miss and waits for the fill
module tlb_miss_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stage_valid,
  input  logic                      split,
  input  logic                      page_carry,
  input  logic                      hit_main,
  input  logic                      hit_next,
  input  logic                      except,
  input  logic [agu_pkg::VPN_W-1:0] vpn_main,
  input  logic                      fill_en,
  output logic                      translated,
  output logic                      miss_req,
  output logic [agu_pkg::VPN_W-1:0] miss_vpn
);
  import agu_pkg::*;

  logic need_next;
  logic miss;
  logic pending_q;

  // the next page matters only for a split access over a page carry
  assign need_next  = page_carry & split;
  assign translated = hit_main & (hit_next | ~need_next);
  assign miss       = stage_valid & ~translated;

  assign miss_req = miss & ~pending_q & ~except;
  // main page first, next page once main hits
  assign miss_vpn = hit_main ? vpn_main + VPN_W'(1) : vpn_main;

  // also drops once the op translates, in case a fill lands with the request
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (except) begin
      pending_q <= 1'b0;
    end else if (miss_req) begin
      pending_q <= 1'b1;
    end else if (fill_en || !miss) begin
      pending_q <= 1'b0;
    end
  end

  a_miss_req_pulse: assert property (
    @(posedge clk) disable iff (rst) miss_req |=> !miss_req
  ) else $error("miss_req repeated while the miss is pending");

endmodule

/* src/access_check.sv */
// access check, tests page permissions of the issued op and reports the fault a cycle later
module access_check (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue,
  input  logic                attr_km,
  input  logic                split,
  input  logic                page_carry,
  input  agu_pkg::tlb_entry_t entry_main,
  input  agu_pkg::tlb_entry_t entry_next,
  output agu_pkg::fault_t     fault
);

  logic [1:0] fault_main;
  logic [1:0] fault_next;
  logic [1:0] fault_bits;
  logic [1:0] fault_q;

  // bit 1 for user access to a system page, bit 0 for a no-access page
  assign fault_main = {~attr_km & entry_main.sys, entry_main.na};
  assign fault_next = {~attr_km & entry_next.sys, entry_next.na};
  assign fault_bits = fault_main | (fault_next & {2{page_carry & split}});

  always_ff @(posedge clk) begin
    if (rst) begin
      fault_q <= 2'b00;
    end else begin
      fault_q <= issue ? fault_bits : 2'b00;
    end
  end

  always_comb begin
    fault.page_fault = |fault_q;
    fault.code       = {4'b0000, fault_q[1], 2'b00, fault_q[0]};
    // 11 in the upper field, 1 below
    fault.no         = fault.page_fault ? {5'd11, 4'd1} : 9'd2;
  end

  a_fault_after_issue: assert property (
    @(posedge clk) disable iff (rst) fault.page_fault |-> $past(issue)
  ) else $error("page fault without a preceding issue");

endmodule

/* src/agu_r.sv */
// agu_r address stage top, joins stage register, dtlb, miss control and address logic
module agu_r (
  input  logic                      clk,
  input  logic                      rst,
  input  agu_pkg::mem_op_in_t       op_in,
  input  logic                      hold,
  input  logic                      except,
  input  agu_pkg::tlb_fill_t        fill,
  output logic                      stall,
  output agu_pkg::mem_op_out_t      mem_op,
  output logic                      miss_req,
  output logic [agu_pkg::VPN_W-1:0] miss_vpn,
  output agu_pkg::fault_t           fault
);
  import agu_pkg::*;

  mem_op_in_t                   stage_op;
  logic                         issue;
  logic                         translated;
  logic [VPN_W-1:0]             vpn_main;
  logic                         hit_main;
  logic                         hit_next;
  tlb_entry_t                   entry_main;
  tlb_entry_t                   entry_next;
  logic                         page_carry;
  logic [PADDR_W-1:LINE_BITS+1] addr_even;
  logic [PADDR_W-1:LINE_BITS+1] addr_odd;
  logic [BANK_COUNT-1:0]        banks;

  assign vpn_main = stage_op.addr[VADDR_W-1:PAGE_BITS];

  op_stage i_op_stage (
    .clk        (clk),
    .rst        (rst),
    .op_in      (op_in),
    .hold       (hold),
    .except     (except),
    .translated (translated),
    .stall      (stall),
    .stage_op   (stage_op),
    .issue      (issue)
  );

  dtlb i_dtlb (
    .clk        (clk),
    .rst        (rst),
    .vpn_main   (vpn_main),
    .fill       (fill),
    .hit_main   (hit_main),
    .hit_next   (hit_next),
    .entry_main (entry_main),
    .entry_next (entry_next)
  );

  line_addr_split i_line_addr_split (
    .addr       (stage_op.addr),
    .entry_main (entry_main),
    .entry_next (entry_next),
    .page_carry (page_carry),
    .addr_even  (addr_even),
    .addr_odd   (addr_odd)
  );

  bank_mask_gen i_bank_mask_gen (
    .addr_low (stage_op.addr[LINE_BITS-1:0]),
    .sz       (stage_op.sz),
    .banks    (banks)
  );

  tlb_miss_ctrl i_tlb_miss_ctrl (
    .clk         (clk),
    .rst         (rst),
    .stage_valid (stage_op.valid),
    .split       (stage_op.split),
    .page_carry  (page_carry),
    .hit_main    (hit_main),
    .hit_next    (hit_next),
    .except      (except),
    .vpn_main    (vpn_main),
    .fill_en     (fill.en),
    .translated  (translated),
    .miss_req    (miss_req),
    .miss_vpn    (miss_vpn)
  );

  access_check i_access_check (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .attr_km    (stage_op.attr[ATTR_KM]),
    .split      (stage_op.split),
    .page_carry (page_carry),
    .entry_main (entry_main),
    .entry_next (entry_next),
    .fault      (fault)
  );

  // issued operation
  always_comb begin
    mem_op.en        = issue;
    mem_op.addr_even = addr_even;
    mem_op.addr_odd  = addr_odd;
    mem_op.odd       = stage_op.addr[LINE_BITS];
    mem_op.addr_low  = stage_op.addr[1:0];
    mem_op.sz        = stage_op.sz;
    mem_op.st        = stage_op.st;
    mem_op.split     = stage_op.split;
    mem_op.banks     = banks;
    mem_op.tag       = stage_op.tag;
  end

endmodule

/* tb/agu_checker.sv */
// address stage scoreboard, mirrors TLB fills and compares the DUT outputs every cycle
module agu_checker (
  input  logic                      clk,
  input  logic                      rst,
  input  agu_pkg::mem_op_in_t       op_in,
  input  logic                      hold,
  input  logic                      except,
  input  agu_pkg::tlb_fill_t        fill,
  input  logic                      stall,
  input  agu_pkg::mem_op_out_t      mem_op,
  input  logic                      miss_req,
  input  logic [agu_pkg::VPN_W-1:0] miss_vpn,
  input  agu_pkg::fault_t           fault,
  output int                        err_count,
  output int                        check_count
);
  import agu_pkg::*;

  typedef struct packed {
    mem_op_out_t op;
    fault_t      fault;
  } expect_t;

  // mirrored TLB, direct mapped on the low VPN bits
  logic             t_valid [TLB_ENTRIES];
  logic [VPN_W-1:0] t_vpn   [TLB_ENTRIES];
  logic [PPN_W-1:0] t_ppn   [TLB_ENTRIES];
  logic             t_sys   [TLB_ENTRIES];
  logic             t_na    [TLB_ENTRIES];

  mem_op_in_t       stage_q [$];
  fault_t           fault_q [$];
  logic             pending;
  logic             have;
  logic             xlat;
  logic             missing;
  logic             e_en;
  logic             e_stall;
  logic             e_miss;
  mem_op_in_t       cur;
  logic [VPN_W-1:0] vpn;
  expect_t          e;
  fault_t           e_fault;

  function automatic int size_bytes(input logic [4:0] sz);
    case (sz)
      SZ_B8:   return 1;
      SZ_B16:  return 2;
      SZ_B32:  return 4;
      SZ_B64:  return 8;
      SZ_LDBL: return 10;
      SZ_FILL: return 20;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: return 16;
      5'd4, 5'd5, 5'd6: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [BANK_COUNT-1:0] bank_ref(input logic [6:0] low, input logic [4:0] sz);
    logic [BANK_COUNT-1:0] m;
    logic [4:0]            b;
    int                    n;
    n = (int'(low[1:0]) + size_bytes(sz) - 1) / 4 + 1;
    if (n > 5) n = 5;
    m = '0;
    for (int i = 0; i < n; i++) begin
      b    = 5'((int'(low[6:2]) + i) % BANK_COUNT);
      m[b] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic tlb_hit(input logic [VPN_W-1:0] v);
    return t_valid[v[TLB_IDX_W-1:0]] && (t_vpn[v[TLB_IDX_W-1:0]] == v);
  endfunction

  // expected issue and fault for a translated op
  function automatic expect_t ref_issue(input mem_op_in_t op);
    expect_t              r;
    logic [VPN_W-1:0]     v;
    logic [VPN_W-1:0]     nv;
    logic [TLB_IDX_W-1:0] im;
    logic [TLB_IDX_W-1:0] inx;
    logic [6:0]           line_a;
    logic [6:0]           line_b;
    logic [6:0]           line_e;
    logic [6:0]           line_o;
    logic                 use_next;
    logic                 f_sys;
    logic                 f_na;
    v      = op.addr[VADDR_W-1:PAGE_BITS];
    nv     = v + VPN_W'(1);
    im     = v[TLB_IDX_W-1:0];
    inx    = nv[TLB_IDX_W-1:0];
    line_a = {1'b0, op.addr[PAGE_BITS-1:LINE_BITS]};
    line_b = line_a + 7'd1;
    line_e = op.addr[LINE_BITS] ? line_b : line_a;
    line_o = op.addr[LINE_BITS] ? line_a : line_b;
    // bit 6 of a line number means it sits in the next page
    r.op.en        = 1'b1;
    r.op.addr_even = {line_e[6] ? t_ppn[inx] : t_ppn[im], line_e[5:1]};
    r.op.addr_odd  = {line_o[6] ? t_ppn[inx] : t_ppn[im], line_o[5:1]};
    r.op.odd       = op.addr[LINE_BITS];
    r.op.addr_low  = op.addr[1:0];
    r.op.sz        = op.sz;
    r.op.st        = op.st;
    r.op.split     = op.split;
    r.op.banks     = bank_ref(op.addr[6:0], op.sz);
    r.op.tag       = op.tag;
    use_next = line_b[6] && op.split;
    f_sys = !op.attr[ATTR_KM] && (t_sys[im] || (use_next && t_sys[inx]));
    f_na  = t_na[im] || (use_next && t_na[inx]);
    r.fault.page_fault = f_sys || f_na;
    r.fault.code       = {4'b0000, f_sys, 3'b000} | {7'b0000000, f_na};
    r.fault.no         = r.fault.page_fault ? 9'(11 * 16 + 1) : 9'd2;
    return r;
  endfunction

  task automatic compare_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
    end
  endtask

  // negedge sampling, values are settled for the coming edge
  always @(negedge clk) begin
    if (rst) begin
      t_valid = '{default: 1'b0};
      stage_q.delete();
      fault_q.delete();
      pending = 1'b0;
    end else begin
      have = (stage_q.size() > 0);
      cur  = '0;
      if (have) cur = stage_q[0];
      vpn     = cur.addr[VADDR_W-1:PAGE_BITS];
      xlat    = tlb_hit(vpn) &&
                (tlb_hit(vpn + VPN_W'(1)) || !((&cur.addr[PAGE_BITS-1:LINE_BITS]) && cur.split));
      missing = have && !xlat;
      e_en    = have && xlat && !hold && !except;
      e_stall = missing || hold;
      e_miss  = missing && !pending && !except;

      compare_value("stall", 160'(stall), 160'(e_stall));
      compare_value("mem_op.en", 160'(mem_op.en), 160'(e_en));
      compare_value("miss_req", 160'(miss_req), 160'(e_miss));
      if (e_miss && miss_req) begin
        compare_value("miss_vpn", 160'(miss_vpn),
                      160'(tlb_hit(vpn) ? vpn + VPN_W'(1) : vpn));
      end

      // fault of the previous issue, idle report otherwise
      e_fault = '{page_fault: 1'b0, code: 8'd0, no: 9'd2};
      if (fault_q.size() > 0) e_fault = fault_q.pop_front();
      compare_value("fault.page_fault", 160'(fault.page_fault), 160'(e_fault.page_fault));
      compare_value("fault.code", 160'(fault.code), 160'(e_fault.code));
      compare_value("fault.no", 160'(fault.no), 160'(e_fault.no));

      if (e_en) begin
        e = ref_issue(cur);
        if (mem_op.en) begin
          compare_value("mem_op.addr_even", 160'(mem_op.addr_even), 160'(e.op.addr_even));
          compare_value("mem_op.addr_odd", 160'(mem_op.addr_odd), 160'(e.op.addr_odd));
          compare_value("mem_op.odd", 160'(mem_op.odd), 160'(e.op.odd));
          compare_value("mem_op.addr_low", 160'(mem_op.addr_low), 160'(e.op.addr_low));
          compare_value("mem_op.banks", 160'(mem_op.banks), 160'(e.op.banks));
          compare_value("mem_op.sz", 160'(mem_op.sz), 160'(e.op.sz));
          compare_value("mem_op.st", 160'(mem_op.st), 160'(e.op.st));
          compare_value("mem_op.split", 160'(mem_op.split), 160'(e.op.split));
          compare_value("mem_op.tag", 160'(mem_op.tag), 160'(e.op.tag));
        end
        fault_q.push_back(e.fault);
      end

      // miss pending flag after the coming edge
      if (except) pending = 1'b0;
      else if (e_miss) pending = 1'b1;
      else if (fill.en || !missing) pending = 1'b0;

      // stage slot after the coming edge
      if (except) begin
        stage_q.delete();
      end else if (!e_stall) begin
        if (have) void'(stage_q.pop_front());
        if (op_in.valid) stage_q.push_back(op_in);
      end

      if (fill.en) begin
        t_valid[fill.vpn[TLB_IDX_W-1:0]] = 1'b1;
        t_vpn[fill.vpn[TLB_IDX_W-1:0]]   = fill.vpn;
        t_ppn[fill.vpn[TLB_IDX_W-1:0]]   = fill.ppn;
        t_sys[fill.vpn[TLB_IDX_W-1:0]]   = fill.sys;
        t_na[fill.vpn[TLB_IDX_W-1:0]]    = fill.na;
      end
    end
  end

endmodule

/* tb/tb_agu.sv */
// address stage testbench, random and directed operations with a TLB fill responder
module tb_agu;
  import agu_pkg::*;

  localparam int               N_OPS      = 400;
  localparam int               WAIT_LIMIT = 200;
  localparam logic [VPN_W-1:0] VPN_BASE   = 31'h0123_4560;

  logic             clk;
  logic             rst;
  mem_op_in_t       op_in;
  logic             hold;
  logic             except;
  tlb_fill_t        fill;
  logic             stall;
  mem_op_out_t      mem_op;
  logic             miss_req;
  logic [VPN_W-1:0] miss_vpn;
  fault_t           fault;
  int               err_count;
  int               check_count;
  int               seed;
  logic             rand_ctl;
  logic             timed_out;
  tlb_fill_t        fill_q [$];
  int               delay_q [$];

  agu_r i_agu_r (
    .clk      (clk),
    .rst      (rst),
    .op_in    (op_in),
    .hold     (hold),
    .except   (except),
    .fill     (fill),
    .stall    (stall),
    .mem_op   (mem_op),
    .miss_req (miss_req),
    .miss_vpn (miss_vpn),
    .fault    (fault)
  );

  agu_checker i_agu_checker (
    .clk         (clk),
    .rst         (rst),
    .op_in       (op_in),
    .hold        (hold),
    .except      (except),
    .fill        (fill),
    .stall       (stall),
    .mem_op      (mem_op),
    .miss_req    (miss_req),
    .miss_vpn    (miss_vpn),
    .fault       (fault),
    .err_count   (err_count),
    .check_count (check_count)
  );

  always #4 clk = ~clk;

  // one fill per miss request, random page and permissions
  always @(negedge clk) begin
    tlb_fill_t f;
    if (!rst && miss_req) begin
      f.en  = 1'b1;
      f.vpn = miss_vpn;
      f.ppn = PPN_W'($random(seed));
      f.sys = (($random(seed) & 3) == 0);
      f.na  = (($random(seed) & 7) == 0);
      fill_q.push_back(f);
      delay_q.push_back(1 + (($random(seed) & 32'h7fff_ffff) % 6));
    end
  end

  always @(posedge clk) begin
    #1;
    fill = '0;
    if (delay_q.size() > 0) begin
      if (delay_q[0] > 1) begin
        delay_q[0] = delay_q[0] - 1;
      end else begin
        fill = fill_q.pop_front();
        void'(delay_q.pop_front());
      end
    end
  end

  task automatic make_op(input logic [VPN_W-1:0] vpn, output mem_op_in_t op);
    logic [PAGE_BITS-1:0] off;
    off = PAGE_BITS'($random(seed));
    // every fourth op starts in the last line of its page
    if (($random(seed) & 3) == 0) off[PAGE_BITS-1:LINE_BITS] = 6'h3f;
    op       = '0;
    op.valid = 1'b1;
    op.addr  = {vpn, off};
    op.sz    = 5'($random(seed));
    op.st    = 1'($random(seed));
    // a page crossing always comes with split
    op.split = 1'($random(seed)) | (&off[PAGE_BITS-1:LINE_BITS]);
    op.attr  = 4'($random(seed));
    op.tag   = 34'({$random(seed), $random(seed)});
  endtask

  task automatic drive_ctl();
    hold   = 1'b0;
    except = 1'b0;
    if (rand_ctl) begin
      hold   = (($random(seed) & 7) == 0);
      except = (($random(seed) & 31) == 0);
    end
  endtask

  // called just after a rising edge, returns just after the accepting edge
  task automatic send_op(input mem_op_in_t op);
    int waited;
    waited = 0;
    op_in  = op;
    drive_ctl();
    @(negedge clk);
    while (stall && !timed_out) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: stage did not accept an operation in %0d cycles", WAIT_LIMIT);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        drive_ctl();
        @(negedge clk);
      end
    end
    @(posedge clk);
    #1;
    op_in.valid = 1'b0;
    drive_ctl();
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while ((stall || mem_op.en) && !timed_out) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: stage did not drain in %0d cycles", WAIT_LIMIT);
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
  endtask

  // keep the op under hold, optionally kill it with except
  task automatic hold_test(input mem_op_in_t op, input logic kill);
    @(posedge clk);
    #1;
    send_op(op);
    hold = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
    end
    if (kill) begin
      except = 1'b1;
      @(posedge clk);
      #1;
      except = 1'b0;
    end
    hold = 1'b0;
    wait_idle();
  endtask

  initial begin
    mem_op_in_t op;
    clk       = 1'b0;
    rst       = 1'b1;
    op_in     = '0;
    hold      = 1'b0;
    except    = 1'b0;
    fill      = '0;
    seed      = 16395;
    rand_ctl  = 1'b0;
    timed_out = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // random traffic over eight pages with random hold and except
    rand_ctl = 1'b1;
    for (int i = 0; i < N_OPS && !timed_out; i++) begin
      make_op(VPN_BASE + VPN_W'($random(seed) & 7), op);
      send_op(op);
    end
    rand_ctl = 1'b0;
    hold     = 1'b0;
    except   = 1'b0;
    if (!timed_out) wait_idle();

    // hold on a hit, except on a hit, except on a fresh page
    if (!timed_out) begin
      make_op(VPN_BASE, op);
      hold_test(op, 1'b0);
    end
    if (!timed_out) begin
      make_op(VPN_BASE + VPN_W'(1), op);
      hold_test(op, 1'b1);
    end
    if (!timed_out) begin
      make_op(VPN_BASE + VPN_W'(12), op);
      hold_test(op, 1'b1);
    end
    repeat (10) @(posedge clk);

    $display("checks %0d errors %0d timeouts %0d", check_count, err_count, timed_out);
    if (err_count == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/agu_pkg.sv
src/op_stage.sv
src/dtlb.sv
src/line_addr_split.sv
src/bank_mask_gen.sv
src/tlb_miss_ctrl.sv
src/access_check.sv
src/agu_r.sv
tb/agu_checker.sv
tb/tb_agu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_agu -f filelist.f

status=0
./obj_dir/Vtb_agu > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
